// File: src/zynq_shell_pkg.sv
`default_nettype none

package zynq_shell_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // bus widths and sizes

   localparam int S_ADDR_W   = 10;
   localparam int DATA_W     = 32;
   localparam int M_ADDR_W   = 32;
   localparam int STRB_W     = DATA_W / 8;

   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_CNT_W = 4;
   localparam int CNT_W      = 32;

   // start of the DRAM window as BlackParrot sees it
   localparam logic [M_ADDR_W-1:0] BP_DRAM_BASE   = 32'h8000_0000;
   localparam logic [DATA_W-1:0]   UNMAPPED_RDATA = 32'hDEAD_BEEF;

   ////////////////////////////////////////////////////////////////////////////
   // register map, byte offsets on the slave port

   typedef enum logic [S_ADDR_W-1:0]
   {
      CSR_PL_RESETN   = 10'h000,
      CSR_DRAM_BASE   = 10'h004,
      CSR_FIFO        = 10'h008,
      CSR_WRITES_DONE = 10'h00C,
      CSR_RESP_ERRS   = 10'h010
   } csr_addr_e;

   // write engine states
   typedef enum logic [1:0]
   {
      E_GET_ADDR,
      E_GET_DATA,
      E_ISSUE,
      E_RESP
   } eng_state_e;

endpackage

`default_nettype wire

// File: src/shell_csr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface shell_csr_if;
   import zynq_shell_pkg::*;

   // register side
   logic                pl_reset;
   logic [M_ADDR_W-1:0] dram_base;

   // engine side
   logic [CNT_W-1:0]    writes_done;
   logic [CNT_W-1:0]    resp_errs;

   modport shell
   (output pl_reset, dram_base
    , input writes_done, resp_errs
   );

   modport engine
   (input pl_reset, dram_base
    , output writes_done, resp_errs
   );

endinterface

`default_nettype wire

// File: src/ps_axil_slave.sv
`timescale 1ns/1ps
`default_nettype none

module ps_axil_slave
  (input  logic                                  aclk_i
   , input  logic                                reset_i

   // write address and data
   , input  logic [zynq_shell_pkg::S_ADDR_W-1:0] s_awaddr_i
   , input  logic                                s_awvalid_i
   , output logic                                s_awready_o
   , input  logic [zynq_shell_pkg::DATA_W-1:0]   s_wdata_i
   , input  logic [zynq_shell_pkg::STRB_W-1:0]   s_wstrb_i
   , input  logic                                s_wvalid_i
   , output logic                                s_wready_o

   // write response
   , output logic [1:0]                          s_bresp_o
   , output logic                                s_bvalid_o
   , input  logic                                s_bready_i

   // read address and data
   , input  logic [zynq_shell_pkg::S_ADDR_W-1:0] s_araddr_i
   , input  logic                                s_arvalid_i
   , output logic                                s_arready_o
   , output logic [zynq_shell_pkg::DATA_W-1:0]   s_rdata_o
   , output logic [1:0]                          s_rresp_o
   , output logic                                s_rvalid_o
   , input  logic                                s_rready_i

   // queue push side
   , output logic [zynq_shell_pkg::DATA_W-1:0]   push_data_o
   , output logic                                push_v_o
   , input  logic                                push_ready_i
   , input  logic [zynq_shell_pkg::FIFO_CNT_W-1:0] fifo_count_i

   , shell_csr_if.shell                          csr
   );

   import zynq_shell_pkg::*;

   logic                pl_resetn_q;
   logic [M_ADDR_W-1:0] dram_base_q;
   logic                bvalid_q;
   logic                rvalid_q;
   logic [DATA_W-1:0]   rdata_q;
   logic [DATA_W-1:0]   rdata_mux;
   logic                aw_is_fifo;
   logic                wr_fire;
   logic                ar_fire;

   assign csr.pl_reset  = reset_i | ~pl_resetn_q;
   assign csr.dram_base = dram_base_q;

   ////////////////////////////////////////////////////////////////////////////
   // write path

   assign aw_is_fifo = (s_awaddr_i == CSR_FIFO);

   // a full queue holds off address and data together
   assign wr_fire = s_awvalid_i & s_wvalid_i & ~bvalid_q
                  & (~aw_is_fifo | push_ready_i | csr.pl_reset);

   assign s_awready_o = wr_fire;
   assign s_wready_o  = wr_fire;
   assign s_bvalid_o  = bvalid_q;
   assign s_bresp_o   = 2'b00;

   // pushes are dropped while the PL is held in reset
   assign push_data_o = s_wdata_i;
   assign push_v_o    = wr_fire & aw_is_fifo & ~csr.pl_reset;

   always_ff @(posedge aclk_i)
   begin
      if (reset_i)
      begin
         pl_resetn_q <= 1'b0;
         dram_base_q <= '0;
         bvalid_q    <= 1'b0;
      end
      else
      begin
         if (wr_fire)
            bvalid_q <= 1'b1;
         else if (s_bready_i)
            bvalid_q <= 1'b0;

         if (wr_fire)
         begin
            case (s_awaddr_i)
               CSR_PL_RESETN:
                  if (s_wstrb_i[0])
                     pl_resetn_q <= s_wdata_i[0];
               CSR_DRAM_BASE:
                  for (int b = 0; b < STRB_W; b++)
                  begin
                     if (s_wstrb_i[b])
                        dram_base_q[8*b +: 8] <= s_wdata_i[8*b +: 8];
                  end
               default:
                  ;
            endcase
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read path

   assign ar_fire     = s_arvalid_i & ~rvalid_q;
   assign s_arready_o = ar_fire;
   assign s_rvalid_o  = rvalid_q;
   assign s_rdata_o   = rdata_q;
   assign s_rresp_o   = 2'b00;

   always_comb
   begin
      case (s_araddr_i)
         CSR_PL_RESETN:   rdata_mux = DATA_W'(pl_resetn_q);
         CSR_DRAM_BASE:   rdata_mux = DATA_W'(dram_base_q);
         CSR_FIFO:        rdata_mux = DATA_W'(fifo_count_i);
         CSR_WRITES_DONE: rdata_mux = DATA_W'(csr.writes_done);
         CSR_RESP_ERRS:   rdata_mux = DATA_W'(csr.resp_errs);
         default:         rdata_mux = UNMAPPED_RDATA;
      endcase
   end

   always_ff @(posedge aclk_i)
   begin
      if (reset_i)
         rvalid_q <= 1'b0;
      else if (ar_fire)
         rvalid_q <= 1'b1;
      else if (s_rready_i)
         rvalid_q <= 1'b0;
   end

   // data is captured once per accepted read
   always_ff @(posedge aclk_i)
   begin
      if (ar_fire)
         rdata_q <= rdata_mux;
   end

   a_bvalid_hold: assert property (@(posedge aclk_i) disable iff (reset_i)
      s_bvalid_o && !s_bready_i |=> s_bvalid_o);

endmodule

`default_nettype wire

// File: src/ps_to_pl_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ps_to_pl_fifo
  (input  logic                                    aclk_i
   , input  logic                                  reset_i

   , input  logic [zynq_shell_pkg::DATA_W-1:0]     push_data_i
   , input  logic                                  push_v_i
   , output logic                                  push_ready_o

   , output logic [zynq_shell_pkg::DATA_W-1:0]     pop_data_o
   , output logic                                  pop_v_o
   , input  logic                                  pop_yumi_i

   , output logic [zynq_shell_pkg::FIFO_CNT_W-1:0] count_o
   );

   import zynq_shell_pkg::*;

   logic [DATA_W-1:0]             mem_q [FIFO_DEPTH];
   logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
   logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
   logic [FIFO_CNT_W-1:0]         count_q;
   logic                          push_fire;

   assign push_ready_o = (count_q != FIFO_CNT_W'(FIFO_DEPTH));
   assign pop_v_o      = (count_q != '0);
   assign pop_data_o   = mem_q[rd_ptr_q];
   assign count_o      = count_q;
   assign push_fire    = push_v_i & push_ready_o;

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge aclk_i)
   begin
      if (reset_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push_fire)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop_yumi_i)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (push_fire && !pop_yumi_i)
            count_q <= count_q + 1'b1;
         else if (!push_fire && pop_yumi_i)
            count_q <= count_q - 1'b1;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (push_fire)
         mem_q[wr_ptr_q] <= push_data_i;
   end

   a_no_underflow: assert property (@(posedge aclk_i) disable iff (reset_i)
      pop_yumi_i |-> pop_v_o);

endmodule

`default_nettype wire

// File: src/dram_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module dram_write_engine
  (input  logic                                  aclk_i

   // queue pop side
   , input  logic [zynq_shell_pkg::DATA_W-1:0]   pop_data_i
   , input  logic                                pop_v_i
   , output logic                                pop_yumi_o

   // AXI-lite master, write channels only
   , output logic [zynq_shell_pkg::M_ADDR_W-1:0] m_awaddr_o
   , output logic                                m_awvalid_o
   , input  logic                                m_awready_i
   , output logic [zynq_shell_pkg::DATA_W-1:0]   m_wdata_o
   , output logic [zynq_shell_pkg::STRB_W-1:0]   m_wstrb_o
   , output logic                                m_wvalid_o
   , input  logic                                m_wready_i
   , input  logic [1:0]                          m_bresp_i
   , input  logic                                m_bvalid_i
   , output logic                                m_bready_o

   , shell_csr_if.engine                         csr
   );

   import zynq_shell_pkg::*;

   eng_state_e          state_q;
   logic                awvalid_q;
   logic                wvalid_q;
   logic [M_ADDR_W-1:0] awaddr_q;
   logic [DATA_W-1:0]   wdata_q;
   logic [CNT_W-1:0]    writes_done_q;
   logic [CNT_W-1:0]    resp_errs_q;
   logic                aw_done;
   logic                w_done;

   // one word per state while gathering the pair
   assign pop_yumi_o = pop_v_i & ((state_q == E_GET_ADDR) | (state_q == E_GET_DATA));

   assign m_awaddr_o  = awaddr_q;
   assign m_awvalid_o = awvalid_q;
   assign m_wdata_o   = wdata_q;
   assign m_wstrb_o   = '1;
   assign m_wvalid_o  = wvalid_q;
   assign m_bready_o  = (state_q == E_RESP);

   assign csr.writes_done = writes_done_q;
   assign csr.resp_errs   = resp_errs_q;

   // channel finished this cycle or earlier
   assign aw_done = ~awvalid_q | m_awready_i;
   assign w_done  = ~wvalid_q | m_wready_i;

   ////////////////////////////////////////////////////////////////////////////
   // control

   always_ff @(posedge aclk_i)
   begin
      if (csr.pl_reset)
      begin
         state_q       <= E_GET_ADDR;
         awvalid_q     <= 1'b0;
         wvalid_q      <= 1'b0;
         writes_done_q <= '0;
         resp_errs_q   <= '0;
      end
      else
      begin
         case (state_q)
            E_GET_ADDR:
               if (pop_v_i)
                  state_q <= E_GET_DATA;
            E_GET_DATA:
               if (pop_v_i)
               begin
                  awvalid_q <= 1'b1;
                  wvalid_q  <= 1'b1;
                  state_q   <= E_ISSUE;
               end
            E_ISSUE:
            begin
               if (m_awready_i)
                  awvalid_q <= 1'b0;
               if (m_wready_i)
                  wvalid_q <= 1'b0;
               if (aw_done && w_done)
                  state_q <= E_RESP;
            end
            E_RESP:
               if (m_bvalid_i)
               begin
                  writes_done_q <= writes_done_q + 1'b1;
                  if (m_bresp_i != 2'b00)
                     resp_errs_q <= resp_errs_q + 1'b1;
                  state_q <= E_GET_ADDR;
               end
            default:
               state_q <= E_GET_ADDR;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // payload

   // flip BP DRAM base off, then move into the window the PS gave us
   always_ff @(posedge aclk_i)
   begin
      if (pop_yumi_o && state_q == E_GET_ADDR)
         awaddr_q <= (M_ADDR_W'(pop_data_i) ^ BP_DRAM_BASE) + csr.dram_base;
      if (pop_yumi_o && state_q == E_GET_DATA)
         wdata_q <= pop_data_i;
   end

   a_aw_hold: assert property (@(posedge aclk_i) disable iff (csr.pl_reset)
      m_awvalid_o && !m_awready_i |=> m_awvalid_o && $stable(m_awaddr_o));

endmodule

`default_nettype wire

// File: src/zynq_shell_top.sv
`timescale 1ns/1ps
`default_nettype none

module zynq_shell_top
  (input  logic                                  aclk_i
   , input  logic                                reset_i

   // PS side, AXI-lite slave
   , input  logic [zynq_shell_pkg::S_ADDR_W-1:0] s00_axil_awaddr_i
   , input  logic                                s00_axil_awvalid_i
   , output logic                                s00_axil_awready_o
   , input  logic [zynq_shell_pkg::DATA_W-1:0]   s00_axil_wdata_i
   , input  logic [zynq_shell_pkg::STRB_W-1:0]   s00_axil_wstrb_i
   , input  logic                                s00_axil_wvalid_i
   , output logic                                s00_axil_wready_o
   , output logic [1:0]                          s00_axil_bresp_o
   , output logic                                s00_axil_bvalid_o
   , input  logic                                s00_axil_bready_i
   , input  logic [zynq_shell_pkg::S_ADDR_W-1:0] s00_axil_araddr_i
   , input  logic                                s00_axil_arvalid_i
   , output logic                                s00_axil_arready_o
   , output logic [zynq_shell_pkg::DATA_W-1:0]   s00_axil_rdata_o
   , output logic [1:0]                          s00_axil_rresp_o
   , output logic                                s00_axil_rvalid_o
   , input  logic                                s00_axil_rready_i

   // DRAM side, AXI-lite master writes
   , output logic [zynq_shell_pkg::M_ADDR_W-1:0] m00_axil_awaddr_o
   , output logic                                m00_axil_awvalid_o
   , input  logic                                m00_axil_awready_i
   , output logic [zynq_shell_pkg::DATA_W-1:0]   m00_axil_wdata_o
   , output logic [zynq_shell_pkg::STRB_W-1:0]   m00_axil_wstrb_o
   , output logic                                m00_axil_wvalid_o
   , input  logic                                m00_axil_wready_i
   , input  logic [1:0]                          m00_axil_bresp_i
   , input  logic                                m00_axil_bvalid_i
   , output logic                                m00_axil_bready_o
   );

   import zynq_shell_pkg::*;

   logic [DATA_W-1:0]     push_data;
   logic                  push_v;
   logic                  push_ready;
   logic [DATA_W-1:0]     pop_data;
   logic                  pop_v;
   logic                  pop_yumi;
   logic [FIFO_CNT_W-1:0] fifo_count;

   shell_csr_if csr_if ();

   ps_axil_slave i_ps_axil_slave
     (.aclk_i        (aclk_i)
      ,.reset_i      (reset_i)
      ,.s_awaddr_i   (s00_axil_awaddr_i)
      ,.s_awvalid_i  (s00_axil_awvalid_i)
      ,.s_awready_o  (s00_axil_awready_o)
      ,.s_wdata_i    (s00_axil_wdata_i)
      ,.s_wstrb_i    (s00_axil_wstrb_i)
      ,.s_wvalid_i   (s00_axil_wvalid_i)
      ,.s_wready_o   (s00_axil_wready_o)
      ,.s_bresp_o    (s00_axil_bresp_o)
      ,.s_bvalid_o   (s00_axil_bvalid_o)
      ,.s_bready_i   (s00_axil_bready_i)
      ,.s_araddr_i   (s00_axil_araddr_i)
      ,.s_arvalid_i  (s00_axil_arvalid_i)
      ,.s_arready_o  (s00_axil_arready_o)
      ,.s_rdata_o    (s00_axil_rdata_o)
      ,.s_rresp_o    (s00_axil_rresp_o)
      ,.s_rvalid_o   (s00_axil_rvalid_o)
      ,.s_rready_i   (s00_axil_rready_i)
      ,.push_data_o  (push_data)
      ,.push_v_o     (push_v)
      ,.push_ready_i (push_ready)
      ,.fifo_count_i (fifo_count)
      ,.csr          (csr_if.shell)
      );

   // queue is held empty while the PL is in reset
   ps_to_pl_fifo i_ps_to_pl_fifo
     (.aclk_i        (aclk_i)
      ,.reset_i      (csr_if.pl_reset)
      ,.push_data_i  (push_data)
      ,.push_v_i     (push_v)
      ,.push_ready_o (push_ready)
      ,.pop_data_o   (pop_data)
      ,.pop_v_o      (pop_v)
      ,.pop_yumi_i   (pop_yumi)
      ,.count_o      (fifo_count)
      );

   dram_write_engine i_dram_write_engine
     (.aclk_i        (aclk_i)
      ,.pop_data_i   (pop_data)
      ,.pop_v_i      (pop_v)
      ,.pop_yumi_o   (pop_yumi)
      ,.m_awaddr_o   (m00_axil_awaddr_o)
      ,.m_awvalid_o  (m00_axil_awvalid_o)
      ,.m_awready_i  (m00_axil_awready_i)
      ,.m_wdata_o    (m00_axil_wdata_o)
      ,.m_wstrb_o    (m00_axil_wstrb_o)
      ,.m_wvalid_o   (m00_axil_wvalid_o)
      ,.m_wready_i   (m00_axil_wready_i)
      ,.m_bresp_i    (m00_axil_bresp_i)
      ,.m_bvalid_i   (m00_axil_bvalid_i)
      ,.m_bready_o   (m00_axil_bready_o)
      ,.csr          (csr_if.engine)
      );

endmodule

`default_nettype wire

// File: tb/tb_zynq_shell.sv
`timescale 1ns/1ps
`default_nettype none

module tb_zynq_shell;
   import zynq_shell_pkg::*;

   localparam int N_BASE  = 4;
   localparam int N_HELD  = 3;
   localparam int N_PAIRS = 20;
   localparam int N_STALL = 12;
   localparam int N_POLL  = 40;
   // rough number of bus transactions in the whole run
   localparam int N_TXN   = 8 + 2*N_BASE + 2*N_HELD + 3*(N_PAIRS + N_STALL) + N_POLL;

   logic aclk_i;
   logic reset_i;
   logic [S_ADDR_W-1:0] s00_axil_awaddr_i, s00_axil_araddr_i;
   logic [DATA_W-1:0]   s00_axil_wdata_i, s00_axil_rdata_o;
   logic [STRB_W-1:0]   s00_axil_wstrb_i;
   logic [1:0]          s00_axil_bresp_o, s00_axil_rresp_o;
   logic s00_axil_awvalid_i, s00_axil_awready_o, s00_axil_wvalid_i, s00_axil_wready_o;
   logic s00_axil_bvalid_o, s00_axil_bready_i;
   logic s00_axil_arvalid_i, s00_axil_arready_o, s00_axil_rvalid_o, s00_axil_rready_i;
   logic [M_ADDR_W-1:0] m00_axil_awaddr_o;
   logic [DATA_W-1:0]   m00_axil_wdata_o;
   logic [STRB_W-1:0]   m00_axil_wstrb_o;
   logic [1:0]          m00_axil_bresp_i;
   logic m00_axil_awvalid_o, m00_axil_awready_i, m00_axil_wvalid_o, m00_axil_wready_i;
   logic m00_axil_bvalid_i, m00_axil_bready_o;

   // memory responder state
   logic        stall;
   logic        aw_got, w_got, logged, resp_pend;
   logic [31:0] got_addr, got_data;
   logic [3:0]  got_strb;

   // model
   logic [31:0] exp_addr_q[$];
   logic [31:0] exp_data_q[$];
   logic [31:0] base;
   int          model_writes, model_errs, max_fill, errors, checks;
   integer      seed = 32'he114_9484;

   zynq_shell_top i_zynq_shell_top (.*);

   initial
   begin
      aclk_i = 1'b0;
      forever #50 aclk_i = ~aclk_i;
   end

   task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                           input string msg);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      end
   endtask

   task automatic axil_write(input logic [S_ADDR_W-1:0] addr, input logic [31:0] data);
      @(negedge aclk_i);
      s00_axil_awaddr_i  = addr;
      s00_axil_wdata_i   = data;
      s00_axil_awvalid_i = 1'b1;
      s00_axil_wvalid_i  = 1'b1;
      #1;
      // a full queue may hold the write off for a while
      while (!s00_axil_awready_o)
      begin
         @(negedge aclk_i);
         #1;
      end
      @(negedge aclk_i);
      s00_axil_awvalid_i = 1'b0;
      s00_axil_wvalid_i  = 1'b0;
      while (!s00_axil_bvalid_o)
         @(negedge aclk_i);
      check_eq(32'(s00_axil_bresp_o), 0, "s00 bresp");
   endtask

   task automatic axil_read(input logic [S_ADDR_W-1:0] addr, output logic [31:0] data);
      @(negedge aclk_i);
      s00_axil_araddr_i  = addr;
      s00_axil_arvalid_i = 1'b1;
      #1;
      while (!s00_axil_arready_o)
      begin
         @(negedge aclk_i);
         #1;
      end
      @(negedge aclk_i);
      s00_axil_arvalid_i = 1'b0;
      while (!s00_axil_rvalid_o)
         @(negedge aclk_i);
      check_eq(32'(s00_axil_rresp_o), 0, "s00 rresp");
      data = s00_axil_rdata_o;
   endtask

   // BP address gets bit 31 flipped and lands at the programmed base
   task automatic push_pair();
      logic [31:0] bp_addr;
      logic [31:0] data;
      bp_addr = $random(seed);
      data    = $random(seed);
      exp_addr_q.push_back({~bp_addr[31], bp_addr[30:0]} + base);
      exp_data_q.push_back(data);
      axil_write(CSR_FIFO, bp_addr);
      axil_write(CSR_FIFO, data);
   endtask

   task automatic log_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      if (exp_addr_q.size() == 0)
      begin
         errors++;
         $display("unexpected m00 write to %h at %0t, no write was pending", addr, $time);
      end
      else
      begin
         check_eq(addr, exp_addr_q.pop_front(), "m00 awaddr");
         check_eq(data, exp_data_q.pop_front(), "m00 wdata");
         check_eq(32'(strb), 32'hF, "m00 wstrb");
      end
   endtask

   task automatic wait_writes(input int n);
      while (model_writes < n)
         @(negedge aclk_i);
      repeat (3) @(negedge aclk_i);
   endtask

   task automatic check_counters();
      logic [31:0] rd;
      axil_read(CSR_WRITES_DONE, rd);
      check_eq(rd, model_writes, "writes done counter");
      axil_read(CSR_RESP_ERRS, rd);
      check_eq(rd, model_errs, "response error counter");
      check_eq(exp_addr_q.size(), 0, "writes still expected");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // memory responder decides at the falling edge what the next rising edge moves

   always @(negedge aclk_i)
   begin
      if (!reset_i)
      begin
         m00_axil_awready_i = !aw_got && !stall && (($random(seed) & 3) != 0);
         m00_axil_wready_i  = !w_got && !stall && (($random(seed) & 3) != 0);
         if (aw_got && w_got && !resp_pend && !stall && (($random(seed) & 1) != 0))
         begin
            resp_pend        = 1'b1;
            m00_axil_bresp_i = (($random(seed) & 7) == 0) ? 2'b10 : 2'b00;
         end
         m00_axil_bvalid_i = resp_pend;
         if (m00_axil_awvalid_o && m00_axil_awready_i)
         begin
            aw_got   = 1'b1;
            got_addr = m00_axil_awaddr_o;
         end
         if (m00_axil_wvalid_o && m00_axil_wready_i)
         begin
            w_got    = 1'b1;
            got_data = m00_axil_wdata_o;
            got_strb = m00_axil_wstrb_o;
         end
         if (aw_got && w_got && !logged)
         begin
            logged = 1'b1;
            log_write(got_addr, got_data, got_strb);
         end
         if (resp_pend && m00_axil_bready_o)
         begin
            model_writes++;
            if (m00_axil_bresp_i != 2'b00)
               model_errs++;
            resp_pend = 1'b0;
            aw_got    = 1'b0;
            w_got     = 1'b0;
            logged    = 1'b0;
         end
      end
   end

   initial
   begin
      repeat (200 * N_TXN) @(posedge aclk_i);
      errors++;
      $display("timeout after %0d cycles, the test did not reach its end", 200 * N_TXN);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("RESULT: FAIL");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // test sequence

   initial
   begin
      logic [31:0] rd;
      {s00_axil_awaddr_i, s00_axil_araddr_i, s00_axil_wdata_i} = '0;
      {s00_axil_awvalid_i, s00_axil_wvalid_i, s00_axil_arvalid_i} = '0;
      s00_axil_wstrb_i  = '1;
      s00_axil_bready_i = 1'b1;
      s00_axil_rready_i = 1'b1;
      {m00_axil_awready_i, m00_axil_wready_i, m00_axil_bvalid_i, m00_axil_bresp_i} = '0;
      {stall, aw_got, w_got, logged, resp_pend} = '0;
      {model_writes, model_errs, max_fill, errors, checks} = '0;
      base    = '0;
      reset_i = 1'b1;
      repeat (4) @(posedge aclk_i);
      @(negedge aclk_i);
      reset_i = 1'b0;

      // reset values and the unmapped read
      axil_read(CSR_PL_RESETN, rd);
      check_eq(rd, 0, "pl reset register after reset");
      axil_read(CSR_WRITES_DONE, rd);
      check_eq(rd, 0, "writes done after reset");
      axil_read(CSR_RESP_ERRS, rd);
      check_eq(rd, 0, "response errors after reset");
      axil_read(10'h020, rd);
      check_eq(rd, 32'hDEAD_BEEF, "unmapped read");

      repeat (N_BASE)
      begin
         base = $random(seed);
         axil_write(CSR_DRAM_BASE, base);
         axil_read(CSR_DRAM_BASE, rd);
         check_eq(rd, base, "dram base readback");
      end

      // pushes while the PL is held in reset are dropped
      repeat (2 * N_HELD) axil_write(CSR_FIFO, $random(seed));
      repeat (20) @(negedge aclk_i);
      axil_read(CSR_FIFO, rd);
      check_eq(rd, 0, "queue occupancy while PL in reset");
      check_eq(model_writes, 0, "m00 writes while PL in reset");

      axil_write(CSR_PL_RESETN, 32'h1);
      axil_read(CSR_PL_RESETN, rd);
      check_eq(rd, 1, "pl reset register after release");
      repeat (N_PAIRS) push_pair();
      wait_writes(N_PAIRS);
      check_counters();

      // a long stall on the memory side lets the queue fill up
      stall = 1'b1;
      fork
         repeat (N_STALL) push_pair();
         begin
            repeat (N_POLL)
            begin
               axil_read(CSR_FIFO, rd);
               check_eq(32'(rd <= FIFO_DEPTH), 1, "queue occupancy bound");
               if (rd > max_fill)
                  max_fill = rd;
            end
            stall = 1'b0;
         end
      join
      check_eq(max_fill, 8, "queue filled during stall");
      wait_writes(N_PAIRS + N_STALL);
      check_counters();

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
src/zynq_shell_pkg.sv
src/shell_csr_if.sv
src/ps_axil_slave.sv
src/ps_to_pl_fifo.sv
src/dram_write_engine.sv
src/zynq_shell_top.sv
tb/tb_zynq_shell.sv

// File: run.sh
#!/bin/sh
# build and run the shell testbench with Verilator
set -e

verilator --binary --timing --assert -Wno-fatal \
   -f build.f --top-module tb_zynq_shell -o sim_zynq_shell

out=$(./obj_dir/sim_zynq_shell)
echo "$out"
echo "$out" | grep -q "RESULT: PASS"
